//--- sim.f
design/qv_pkg.sv
design/qv_bus_router.sv
design/qspi_shifter.sv
design/qspi_mem_ctrl.sv
design/qv_mem_subsys.sv
sim/qspi_mem_model.sv
sim/tb_assert.sv
sim/tb_qv_mem_subsys.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP       = tb_qv_mem_subsys
FILELIST  = sim.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "^STATUS: PASS$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- sim/tb_qv_mem_subsys.sv
// Memory subsystem testbench
`timescale 1ns/1ps
`default_nettype none

module tb_qv_mem_subsys;

  import qv_pkg::*;

  localparam int unsigned DUMMY_NIBBLES = 4;
  localparam int    CLK_PERIOD     = 20;
  localparam int    N_DIRECTED     = 20;
  localparam int    N_RANDOM       = 200;
  localparam int    CYCLES_PER_TXN = 200;
  localparam int    TIMEOUT_NS     = (N_DIRECTED + N_RANDOM + 2) * CYCLES_PER_TXN * CLK_PERIOD;
  localparam addr_t RAM_A_ADDR     = {3'b000, RAM_A_BASE};
  localparam addr_t RAM_B_ADDR     = {3'b000, RAM_B_BASE};

  logic      clk;
  logic      arst_n;
  addr_t     data_addr;
  txn_size_t data_write_n;
  txn_size_t data_read_n;
  word_t     data_out;
  logic      data_ready;
  word_t     data_in;
  addr_t     periph_addr;
  txn_size_t periph_write_n;
  txn_size_t periph_read_n;
  word_t     periph_wdata;
  logic      periph_ready;
  word_t     periph_rdata;
  nibble_t   spi_data_in;
  nibble_t   spi_data_out;
  nibble_t   spi_data_oe;
  logic      spi_clk_out;
  logic      spi_flash_select;
  logic      spi_ram_a_select;
  logic      spi_ram_b_select;

  logic [7:0] shadow_a [0:4095];  // Expected RAM contents
  logic [7:0] shadow_b [0:4095];
  integer     seed;
  int         txn_count;
  logic       pending;
  logic       pending_read;
  word_t      exp_rdata;
  logic       periph_busy;
  int         periph_wait;

  qv_mem_subsys #(.DUMMY_NIBBLES(DUMMY_NIBBLES)) dut_i (.*);

  qspi_mem_model #(.DUMMY_NIBBLES(DUMMY_NIBBLES)) mem_model_i (
    .spi_clk_out      (spi_clk_out),
    .spi_data_out     (spi_data_out),
    .spi_data_in      (spi_data_in),
    .spi_flash_select (spi_flash_select),
    .spi_ram_a_select (spi_ram_a_select),
    .spi_ram_b_select (spi_ram_b_select)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = !clk;

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("STATUS: FAIL");
    $fatal(1, "Run stopped on first error");
  endtask

  task automatic check_value(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      fail_run($sformatf("Fail at %0d ns: %s is %h, expected %h", $time, name, got, exp));
    end
  endtask

  function automatic int size_bytes(input txn_size_t size);
    case (size)
      SIZE_BYTE: return 1;
      SIZE_HALF: return 2;
      default:   return 4;
    endcase
  endfunction

  function automatic logic [7:0] mem_byte(input mem_addr_t a);
    logic [7:0] b;
    if (a >= RAM_B_BASE) begin
      b = shadow_b[a[11:0]];
    end else if (a >= RAM_A_BASE) begin
      b = shadow_a[a[11:0]];
    end else begin
      b = a[7:0] ^ 8'ha5;  // Flash preload rule
    end
    return b;
  endfunction

  // Expected read data: little-endian bytes, zero-extended by size
  function automatic word_t expected_read(input addr_t addr, input txn_size_t size);
    word_t w;
    w = '0;
    if (addr[27:25] != 3'b000) begin
      w = {4'h0, addr} ^ 32'h5a5a_5a5a;  // Peripheral answer
    end else begin
      for (int i = 0; i < size_bytes(size); i++) begin
        w[8*i +: 8] = mem_byte(addr[24:0] + 25'(i));
      end
    end
    return w;
  endfunction

  task automatic shadow_write(input addr_t addr, input txn_size_t size, input word_t d);
    mem_addr_t a;
    if (addr[27:25] == 3'b000) begin
      for (int i = 0; i < size_bytes(size); i++) begin
        a = addr[24:0] + 25'(i);
        if (a >= RAM_B_BASE) begin
          shadow_b[a[11:0]] = d[8*i +: 8];
        end else if (a >= RAM_A_BASE) begin
          shadow_a[a[11:0]] = d[8*i +: 8];
        end
      end
    end
  endtask

  // Holds one request until data_ready, then drops it
  task automatic run_txn(input addr_t addr, input logic is_write, input txn_size_t size,
                         input word_t wdata);
    exp_rdata    = expected_read(addr, size);
    pending      = 1'b1;
    pending_read = !is_write;
    data_addr    = addr;
    data_out     = wdata;
    data_write_n = is_write ? size : SIZE_NONE;
    data_read_n  = is_write ? SIZE_NONE : size;
    do begin
      @(posedge clk);
    end while (!data_ready);
    #1;
    pending      = 1'b0;
    data_write_n = SIZE_NONE;
    data_read_n  = SIZE_NONE;
    if (is_write) shadow_write(addr, size, wdata);
    txn_count++;
  endtask

  // Compare read data on every ready pulse
  always @(posedge clk) begin
    if (arst_n && data_ready) begin
      if (!pending) begin
        fail_run($sformatf("data_ready pulsed at %0d ns with no request open", $time));
      end else if (pending_read) begin
        check_value("data_in", data_in, exp_rdata);
      end
    end
  end

  // Peripheral responder, random latency of 0 to 3 cycles
  always @(posedge clk) begin : periph_responder
    logic  is_periph;
    logic  req_on;
    logic  respond;
    word_t rdata_next;
    is_periph  = (data_addr[27:25] != 3'b000);
    req_on     = (periph_write_n != SIZE_NONE) || (periph_read_n != SIZE_NONE);
    respond    = 1'b0;
    rdata_next = {4'h0, periph_addr} ^ 32'h5a5a_5a5a;
    check_value("periph_write_n", 32'(periph_write_n),
                32'(is_periph ? data_write_n : SIZE_NONE));
    check_value("periph_read_n", 32'(periph_read_n), 32'(is_periph ? data_read_n : SIZE_NONE));
    check_value("periph_addr", 32'(periph_addr), 32'(data_addr));
    check_value("periph_wdata", periph_wdata, data_out);
    if (req_on) begin
      check_value("chip selects",
                  32'({spi_flash_select, spi_ram_a_select, spi_ram_b_select}), 32'h7);
    end
    if (periph_ready) begin
      periph_busy = 1'b0;  // Request ends at this edge
    end else if (req_on && !periph_busy) begin
      periph_busy = 1'b1;
      periph_wait = $unsigned($random(seed)) % 4;
      respond     = (periph_wait == 0);
    end else if (periph_busy) begin
      periph_wait--;
      respond = (periph_wait == 0);
    end
    #1;
    periph_ready = respond;
    periph_rdata = respond ? rdata_next : '0;
  end

  initial begin : watchdog
    #(TIMEOUT_NS);
    fail_run($sformatf("Timeout: no progress after %0d transactions", txn_count));
  end

  initial begin : stimulus
    addr_t     addr;
    logic      wr;
    txn_size_t size;
    word_t     wdata;
    int        region;
    int        offset;
    seed         = 81882;
    txn_count    = 0;
    pending      = 1'b0;
    pending_read = 1'b0;
    exp_rdata    = '0;
    periph_busy  = 1'b0;
    periph_wait  = 0;
    arst_n       = 1'b0;
    data_addr    = '0;
    data_write_n = SIZE_NONE;
    data_read_n  = SIZE_NONE;
    data_out     = '0;
    periph_ready = 1'b0;
    periph_rdata = '0;
    for (int i = 0; i < 4096; i++) begin
      shadow_a[i] = 8'h00;
      shadow_b[i] = 8'h00;
    end
    repeat (3) @(posedge clk);
    #1 arst_n = 1'b1;
    @(posedge clk);
    #1;

    // RAM A, each size written and read back
    run_txn(RAM_A_ADDR + 28'h10, 1'b1, SIZE_WORD, 32'h1234_5678);
    run_txn(RAM_A_ADDR + 28'h10, 1'b0, SIZE_WORD, '0);
    run_txn(RAM_A_ADDR + 28'h11, 1'b0, SIZE_BYTE, '0);
    run_txn(RAM_A_ADDR + 28'h12, 1'b0, SIZE_HALF, '0);
    run_txn(RAM_A_ADDR + 28'h20, 1'b1, SIZE_HALF, 32'hdead_beef);
    run_txn(RAM_A_ADDR + 28'h20, 1'b0, SIZE_WORD, '0);
    run_txn(RAM_A_ADDR + 28'h30, 1'b1, SIZE_BYTE, 32'hffff_ff9c);
    run_txn(RAM_A_ADDR + 28'h30, 1'b0, SIZE_HALF, '0);
    run_txn(RAM_A_ADDR + 28'h30, 1'b0, SIZE_BYTE, '0);
    // Same in-chip offset in RAM B
    run_txn(RAM_B_ADDR + 28'h10, 1'b1, SIZE_WORD, 32'hcafe_f00d);
    run_txn(RAM_B_ADDR + 28'h10, 1'b0, SIZE_WORD, '0);
    run_txn(RAM_A_ADDR + 28'h10, 1'b0, SIZE_WORD, '0);
    // Flash reads, and a dropped write
    run_txn(28'h000_0123, 1'b0, SIZE_WORD, '0);
    run_txn(28'h000_02fe, 1'b0, SIZE_HALF, '0);
    run_txn(28'h000_0123, 1'b1, SIZE_WORD, 32'h0000_0000);
    run_txn(28'h000_0123, 1'b0, SIZE_WORD, '0);
    // Peripheral bus
    run_txn(28'h200_0040, 1'b1, SIZE_WORD, 32'h0bad_cafe);
    run_txn(28'h7ff_fffc, 1'b0, SIZE_WORD, '0);
    run_txn(28'ha00_0001, 1'b0, SIZE_BYTE, '0);
    run_txn(28'h400_0010, 1'b1, SIZE_HALF, 32'h1111_2222);

    for (int n = 0; n < N_RANDOM; n++) begin
      region = $unsigned($random(seed)) % 4;
      offset = $unsigned($random(seed)) % 4088;  // Keeps bursts inside one chip
      case (region)
        0:       addr = 28'(offset);
        1:       addr = RAM_A_ADDR + 28'(offset);
        2:       addr = RAM_B_ADDR + 28'(offset);
        default: addr = {3'(1 + $unsigned($random(seed)) % 7), 25'($random(seed))};
      endcase
      size  = 2'($unsigned($random(seed)) % 3);
      wr    = 1'($random(seed));
      wdata = $random(seed);
      run_txn(addr, wr, size, wdata);
    end

    @(posedge clk);
    $display("STATUS: PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- sim/tb_assert.sv
// Memory controller bus checks
`timescale 1ns/1ps
`default_nettype none

module tb_assert (
  input logic            clk,
  input logic            arst_n,
  input logic            ctrl_idle,
  input logic            ctrl_reading,
  input qv_pkg::nibble_t spi_data_oe,
  input logic            spi_flash_select,
  input logic            spi_ram_a_select,
  input logic            spi_ram_b_select
);

  logic [2:0] selects;

  assign selects = {spi_flash_select, spi_ram_a_select, spi_ram_b_select};

  one_chip_low: assert property (@(posedge clk) disable iff (!arst_n)
    $onehot0(~selects))
    else $error("More than one chip select is low");

  // Lanes switch together and only inside a frame
  oe_all_or_none: assert property (@(posedge clk) disable iff (!arst_n)
    (spi_data_oe == 4'h0) || ((spi_data_oe == 4'hf) && (selects != 3'b111)))
    else $error("Output enable lanes disagree or drive with no chip selected");

  read_lanes_released: assert property (@(posedge clk) disable iff (!arst_n)
    ctrl_reading |-> (spi_data_oe == 4'h0))
    else $error("Output enable on during read turnaround or read data");

  idle_deselected: assert property (@(posedge clk) disable iff (!arst_n)
    ctrl_idle |-> (selects == 3'b111))
    else $error("Chip select low while the controller is idle");

endmodule

bind qspi_mem_ctrl tb_assert assert_i (
  .clk              (clk),
  .arst_n           (arst_n),
  .ctrl_idle        (state == ST_IDLE),
  .ctrl_reading     (read_q && (state == ST_DUMMY || state == ST_DATA)),
  .spi_data_oe      (spi_data_oe),
  .spi_flash_select (spi_flash_select),
  .spi_ram_a_select (spi_ram_a_select),
  .spi_ram_b_select (spi_ram_b_select)
);

`default_nettype wire

//--- sim/qspi_mem_model.sv
// QSPI flash and RAM chip model
`timescale 1ns/1ps
`default_nettype none

module qspi_mem_model #(
  parameter int unsigned DUMMY_NIBBLES = 4
) (
  input  logic            spi_clk_out,
  input  qv_pkg::nibble_t spi_data_out,
  output qv_pkg::nibble_t spi_data_in,
  input  logic            spi_flash_select,
  input  logic            spi_ram_a_select,
  input  logic            spi_ram_b_select
);

  import qv_pkg::*;

  logic [7:0]  flash [0:4095];  // Low 12 offset bits only
  logic [7:0]  ram_a [0:4095];
  logic [7:0]  ram_b [0:4095];
  int unsigned rise_cnt;        // Nibbles clocked in this frame
  int unsigned k;
  logic [7:0]  cmd;
  logic [23:0] offset;
  logic [7:0]  wr_byte;
  logic [7:0]  rd_byte;
  logic        frame_idle;

  assign frame_idle = spi_flash_select & spi_ram_a_select & spi_ram_b_select;

  initial begin
    for (int i = 0; i < 4096; i++) begin
      flash[i] = 8'(i) ^ 8'ha5;
      ram_a[i] = 8'h00;
      ram_b[i] = 8'h00;
    end
    rise_cnt    = 0;
    spi_data_in = 4'h0;
  end

  always @(posedge frame_idle) begin
    rise_cnt    = 0;
    spi_data_in = 4'h0;
  end

  // Chips sample on the rising QSPI clock
  always @(posedge spi_clk_out) begin
    if (rise_cnt < 2) begin
      cmd = {cmd[3:0], spi_data_out};
    end else if (rise_cnt < 8) begin
      offset = {offset[19:0], spi_data_out};
    end else if (cmd == CMD_WRITE) begin
      wr_byte = {wr_byte[3:0], spi_data_out};
      if (rise_cnt[0]) begin  // Low nibble closes the byte
        if (!spi_flash_select) flash[12'(offset + 24'((rise_cnt - 8) / 2))] = wr_byte;
        if (!spi_ram_a_select) ram_a[12'(offset + 24'((rise_cnt - 8) / 2))] = wr_byte;
        if (!spi_ram_b_select) ram_b[12'(offset + 24'((rise_cnt - 8) / 2))] = wr_byte;
      end
    end
    rise_cnt++;
  end

  // Read data goes out after the falling QSPI clock, past the dummy nibbles
  always @(negedge spi_clk_out) begin
    if (!frame_idle && cmd == CMD_READ && rise_cnt >= 8 + DUMMY_NIBBLES) begin
      k = rise_cnt - (8 + DUMMY_NIBBLES);
      if (!spi_flash_select) begin
        rd_byte = flash[12'(offset + 24'(k / 2))];
      end else if (!spi_ram_a_select) begin
        rd_byte = ram_a[12'(offset + 24'(k / 2))];
      end else begin
        rd_byte = ram_b[12'(offset + 24'(k / 2))];
      end
      spi_data_in = k[0] ? rd_byte[3:0] : rd_byte[7:4];  // High nibble first
    end
  end

endmodule

`default_nettype wire

//--- design/qv_mem_subsys.sv
// Memory subsystem top level
`timescale 1ns/1ps
`default_nettype none

module qv_mem_subsys #(
  parameter int unsigned DUMMY_NIBBLES = 4
) (
  input  logic              clk,
  input  logic              arst_n,

  // Processor data bus
  input  qv_pkg::addr_t     data_addr,
  input  qv_pkg::txn_size_t data_write_n,  // SIZE_NONE when no write
  input  qv_pkg::txn_size_t data_read_n,   // SIZE_NONE when no read
  input  qv_pkg::word_t     data_out,
  output logic              data_ready,
  output qv_pkg::word_t     data_in,

  // External peripheral bus
  output qv_pkg::addr_t     periph_addr,
  output qv_pkg::txn_size_t periph_write_n,
  output qv_pkg::txn_size_t periph_read_n,
  output qv_pkg::word_t     periph_wdata,
  input  logic              periph_ready,
  input  qv_pkg::word_t     periph_rdata,

  // QSPI pins
  input  qv_pkg::nibble_t   spi_data_in,
  output qv_pkg::nibble_t   spi_data_out,
  output qv_pkg::nibble_t   spi_data_oe,
  output logic              spi_clk_out,
  output logic              spi_flash_select,
  output logic              spi_ram_a_select,
  output logic              spi_ram_b_select
);

  import qv_pkg::*;

  // Router to memory controller
  txn_size_t mem_write_n;
  txn_size_t mem_read_n;
  logic      mem_ready;
  word_t     mem_rdata;

  // Address and data go out on the peripheral bus unconditionally
  assign periph_addr  = data_addr;
  assign periph_wdata = data_out;

  qv_bus_router router_i (
    .req_addr        (data_addr),
    .req_write_n     (data_write_n),
    .req_read_n      (data_read_n),
    .mem_write_n     (mem_write_n),
    .mem_read_n      (mem_read_n),
    .mem_ready       (mem_ready),
    .mem_rdata       (mem_rdata),
    .periph_write_n  (periph_write_n),
    .periph_read_n   (periph_read_n),
    .periph_ready_in (periph_ready),
    .periph_rdata_in (periph_rdata),
    .rsp_ready       (data_ready),
    .rsp_rdata       (data_in)
  );

  qspi_mem_ctrl #(
    .DUMMY_NIBBLES (DUMMY_NIBBLES)
  ) mem_ctrl_i (
    .clk              (clk),
    .arst_n           (arst_n),
    .data_addr        (data_addr[24:0]),  // Offset inside the memory region
    .data_write_n     (mem_write_n),
    .data_read_n      (mem_read_n),
    .data_to_write    (data_out),
    .data_ready       (mem_ready),
    .data_from_read   (mem_rdata),
    .spi_data_in      (spi_data_in),
    .spi_data_out     (spi_data_out),
    .spi_data_oe      (spi_data_oe),
    .spi_clk_out      (spi_clk_out),
    .spi_flash_select (spi_flash_select),
    .spi_ram_a_select (spi_ram_a_select),
    .spi_ram_b_select (spi_ram_b_select)
  );

endmodule

`default_nettype wire

//--- design/qspi_mem_ctrl.sv
// QSPI flash and RAM controller
`timescale 1ns/1ps
`default_nettype none

module qspi_mem_ctrl #(
  parameter int unsigned DUMMY_NIBBLES = 4  // Read turnaround length
) (
  input  logic              clk,
  input  logic              arst_n,

  // Memory request, held until data_ready
  input  qv_pkg::mem_addr_t data_addr,
  input  qv_pkg::txn_size_t data_write_n,
  input  qv_pkg::txn_size_t data_read_n,
  input  qv_pkg::word_t     data_to_write,
  output logic              data_ready,
  output qv_pkg::word_t     data_from_read,

  // QSPI pins
  input  qv_pkg::nibble_t   spi_data_in,
  output qv_pkg::nibble_t   spi_data_out,
  output qv_pkg::nibble_t   spi_data_oe,
  output logic              spi_clk_out,
  output logic              spi_flash_select,
  output logic              spi_ram_a_select,
  output logic              spi_ram_b_select
);

  import qv_pkg::*;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_CMD,
    ST_ADDR,
    ST_DUMMY,
    ST_DATA,
    ST_FINISH
  } state_t;

  state_t     state;
  txn_size_t  req_size;
  logic       req_valid;
  logic       req_is_read;
  logic       hit_flash;
  logic       hit_ram_a;
  logic       hit_ram_b;
  mem_addr_t  chip_offset;
  txn_size_t  size_q;
  logic       read_q;
  word_t      wdata_swapped;
  word_t      rdata_packed;

  // Shifter handshake
  logic       shift_start;
  logic [3:0] shift_nibbles;
  word_t      shift_out;
  logic       shift_drive;
  logic       shift_done;
  word_t      shift_in;

  // Two nibbles per byte on the wire
  function automatic logic [3:0] size_nibbles(input txn_size_t size);
    logic [3:0] n;
    case (size)
      SIZE_BYTE: n = 4'd2;
      SIZE_HALF: n = 4'd4;
      default:   n = 4'd8;
    endcase
    return n;
  endfunction

  assign req_is_read = (data_read_n != SIZE_NONE);
  assign req_valid   = req_is_read || (data_write_n != SIZE_NONE);
  assign req_size    = req_is_read ? data_read_n : data_write_n;

  // Chip decode
  assign hit_ram_b = (data_addr >= RAM_B_BASE);
  assign hit_ram_a = (data_addr >= RAM_A_BASE) && !hit_ram_b;
  assign hit_flash = (data_addr < RAM_A_BASE);

  always_comb begin
    if (hit_ram_b) begin
      chip_offset = data_addr - RAM_B_BASE;
    end else if (hit_ram_a) begin
      chip_offset = data_addr - RAM_A_BASE;
    end else begin
      chip_offset = data_addr;
    end
  end

  // Byte 0 goes out first, high nibble first within each byte
  assign wdata_swapped = {data_to_write[7:0], data_to_write[15:8],
                          data_to_write[23:16], data_to_write[31:24]};

  // Stream arrives byte 0 first, so undo the order per size
  always_comb begin
    case (size_q)
      SIZE_BYTE: rdata_packed = {24'h0, shift_in[7:0]};
      SIZE_HALF: rdata_packed = {16'h0, shift_in[7:0], shift_in[15:8]};
      default:   rdata_packed = {shift_in[7:0], shift_in[15:8],
                                 shift_in[23:16], shift_in[31:24]};
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state            <= ST_IDLE;
      size_q           <= SIZE_NONE;
      read_q           <= 1'b0;
      shift_start      <= 1'b0;
      shift_nibbles    <= 4'd0;
      shift_out        <= '0;
      shift_drive      <= 1'b0;
      data_ready       <= 1'b0;
      spi_flash_select <= 1'b1;
      spi_ram_a_select <= 1'b1;
      spi_ram_b_select <= 1'b1;
    end else begin
      shift_start <= 1'b0;
      data_ready  <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (req_valid) begin
            size_q <= req_size;
            read_q <= req_is_read;
            if (hit_flash && !req_is_read) begin
              data_ready <= 1'b1;  // Flash is read-only, drop the write
              state      <= ST_FINISH;
            end else begin
              spi_flash_select <= !hit_flash;
              spi_ram_a_select <= !hit_ram_a;
              spi_ram_b_select <= !hit_ram_b;
              shift_out     <= {(req_is_read ? CMD_READ : CMD_WRITE), 24'h0};
              shift_nibbles <= 4'd2;
              shift_drive   <= 1'b1;
              shift_start   <= 1'b1;
              state         <= ST_CMD;
            end
          end
        end
        ST_CMD: begin
          if (shift_done) begin
            shift_out     <= {chip_offset[23:0], 8'h00};
            shift_nibbles <= 4'd6;
            shift_start   <= 1'b1;
            state         <= ST_ADDR;
          end
        end
        ST_ADDR: begin
          if (shift_done) begin
            shift_start <= 1'b1;
            if (read_q) begin
              shift_nibbles <= 4'(DUMMY_NIBBLES);
              shift_drive   <= 1'b0;  // Release the lanes for turnaround
              state         <= ST_DUMMY;
            end else begin
              shift_out     <= wdata_swapped;
              shift_nibbles <= size_nibbles(size_q);
              state         <= ST_DATA;
            end
          end
        end
        ST_DUMMY: begin
          if (shift_done) begin
            shift_nibbles <= size_nibbles(size_q);
            shift_start   <= 1'b1;
            state         <= ST_DATA;
          end
        end
        ST_DATA: begin
          if (shift_done) begin
            spi_flash_select <= 1'b1;
            spi_ram_a_select <= 1'b1;
            spi_ram_b_select <= 1'b1;
            shift_drive      <= 1'b0;
            data_ready       <= 1'b1;
            state            <= ST_FINISH;
          end
        end
        default: state <= ST_IDLE;  // FINISH keeps selects high a cycle
      endcase
    end
  end

  // Read result, held until the next read completes
  always_ff @(posedge clk) begin
    if (state == ST_DATA && shift_done && read_q) begin
      data_from_read <= rdata_packed;
    end
  end

  qspi_shifter shifter_i (
    .clk           (clk),
    .arst_n        (arst_n),
    .shift_start   (shift_start),
    .shift_nibbles (shift_nibbles),
    .shift_out     (shift_out),
    .shift_drive   (shift_drive),
    .shift_done    (shift_done),
    .shift_in      (shift_in),
    .spi_data_in   (spi_data_in),
    .spi_data_out  (spi_data_out),
    .spi_data_oe   (spi_data_oe),
    .spi_clk_out   (spi_clk_out)
  );

endmodule

`default_nettype wire

//--- design/qspi_shifter.sv
// QSPI nibble shifter
`timescale 1ns/1ps
`default_nettype none

module qspi_shifter (
  input  logic            clk,
  input  logic            arst_n,

  // Control from the sequencer
  input  logic            shift_start,    // One-cycle pulse
  input  logic [3:0]      shift_nibbles,  // Nibbles in this burst
  input  qv_pkg::word_t   shift_out,      // Sent MSB nibble first
  input  logic            shift_drive,    // Drive lanes when set
  output logic            shift_done,
  output qv_pkg::word_t   shift_in,       // Captured nibbles, newest at the bottom

  // QSPI pins
  input  qv_pkg::nibble_t spi_data_in,
  output qv_pkg::nibble_t spi_data_out,
  output qv_pkg::nibble_t spi_data_oe,
  output logic            spi_clk_out
);

  import qv_pkg::*;

  logic       active;
  logic [3:0] nib_cnt;  // Nibbles still to go
  word_t      out_sreg;

  assign spi_data_out = out_sreg[31:28];
  assign spi_data_oe  = (active && shift_drive) ? 4'hf : 4'h0;

  // Clock generation and nibble count
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      active      <= 1'b0;
      nib_cnt     <= 4'd0;
      spi_clk_out <= 1'b0;
      shift_done  <= 1'b0;
    end else begin
      shift_done <= 1'b0;
      if (shift_start) begin
        active      <= 1'b1;
        nib_cnt     <= shift_nibbles;
        spi_clk_out <= 1'b0;
      end else if (active) begin
        spi_clk_out <= !spi_clk_out;
        // Falling edge closes the current nibble
        if (spi_clk_out) begin
          nib_cnt <= nib_cnt - 4'd1;
          if (nib_cnt == 4'd1) begin
            active     <= 1'b0;
            shift_done <= 1'b1;
          end
        end
      end
    end
  end

  // Data moves on the edge that takes the QSPI clock low
  always_ff @(posedge clk) begin
    if (shift_start) begin
      out_sreg <= shift_out;
      shift_in <= '0;  // Short reads come back zero-filled
    end else if (active && spi_clk_out) begin
      out_sreg <= {out_sreg[27:0], 4'h0};
      if (!shift_drive) begin
        shift_in <= {shift_in[27:0], spi_data_in};
      end
    end
  end

endmodule

`default_nettype wire

//--- design/qv_bus_router.sv
// Data bus region router
`timescale 1ns/1ps
`default_nettype none

module qv_bus_router (
  // Request from the processor side
  input  qv_pkg::addr_t     req_addr,
  input  qv_pkg::txn_size_t req_write_n,
  input  qv_pkg::txn_size_t req_read_n,

  // Memory controller side
  output qv_pkg::txn_size_t mem_write_n,
  output qv_pkg::txn_size_t mem_read_n,
  input  logic              mem_ready,
  input  qv_pkg::word_t     mem_rdata,

  // External peripheral side
  output qv_pkg::txn_size_t periph_write_n,
  output qv_pkg::txn_size_t periph_read_n,
  input  logic              periph_ready_in,
  input  qv_pkg::word_t     periph_rdata_in,

  // Response back to the processor
  output logic              rsp_ready,
  output qv_pkg::word_t     rsp_rdata
);

  import qv_pkg::*;

  logic is_mem;

  // Memory region is the bottom 32 MB of the address space
  assign is_mem = (req_addr[27:25] == 3'b000);

  // Only the selected side ever sees an active size code
  assign mem_write_n    = is_mem ? req_write_n : SIZE_NONE;
  assign mem_read_n     = is_mem ? req_read_n  : SIZE_NONE;
  assign periph_write_n = is_mem ? SIZE_NONE   : req_write_n;
  assign periph_read_n  = is_mem ? SIZE_NONE   : req_read_n;

  // Response comes from whichever side owns the address
  always_comb begin
    if (is_mem) begin
      rsp_ready = mem_ready;
      rsp_rdata = mem_rdata;
    end else begin
      rsp_ready = periph_ready_in;  // Same-cycle pass-through
      rsp_rdata = periph_rdata_in;
    end
  end

endmodule

`default_nettype wire

//--- design/qv_pkg.sv
// Memory subsystem shared definitions
`default_nettype none

package qv_pkg;

  // Bus widths
  typedef logic [27:0] addr_t;      // Full data-bus address
  typedef logic [24:0] mem_addr_t;  // Address inside the memory region
  typedef logic [31:0] word_t;
  typedef logic [3:0]  nibble_t;    // QSPI lane group

  // Transaction size codes, shared by read and write requests
  typedef logic [1:0] txn_size_t;

  localparam txn_size_t SIZE_BYTE = 2'b00;
  localparam txn_size_t SIZE_HALF = 2'b01;
  localparam txn_size_t SIZE_WORD = 2'b10;
  localparam txn_size_t SIZE_NONE = 2'b11;  // No request

  // QSPI command bytes
  localparam logic [7:0] CMD_READ  = 8'heb;  // Quad I/O read
  localparam logic [7:0] CMD_WRITE = 8'h38;  // Quad write

  // Memory map inside the memory region
  // Flash sits below RAM A, RAM B runs to the top of the region
  localparam mem_addr_t RAM_A_BASE = 25'h1000000;
  localparam mem_addr_t RAM_B_BASE = 25'h1800000;

endpackage

`default_nettype wire
